// ==== rtl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // line geometry
    localparam int OFFSET_W       = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_WAYS       = 2;
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;

    // main controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REPLACE,
        REFILL
    } cache_state_e;

    // write buffer states
    typedef enum logic {
        WB_IDLE,
        WB_WRITE
    } wb_state_e;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_e;

endpackage

`default_nettype wire

// ==== rtl/sram_1rw.sv ====
`default_nettype none

module sram_1rw #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 8,
    parameter bit BYTE_EN = 1'b0,
    localparam int WE_W = BYTE_EN ? DATA_W / 8 : 1
) (
    input  logic              clk,
    input  logic [WE_W-1:0]   we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata
);

    // one write lane per enable bit
    localparam int LANE_W = DATA_W / WE_W;

    logic [DATA_W-1:0] mem [2**ADDR_W];

    // read returns the old contents on a write to the same address
    always_ff @(posedge clk)
    begin
        for (int l = 0; l < WE_W; l++)
        begin
            if (we[l])
                mem[addr][l*LANE_W +: LANE_W] <= wdata[l*LANE_W +: LANE_W];
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== rtl/cache_tag_array.sv ====
`default_nettype none

module cache_tag_array #(
    parameter int INDEX_W = 8,
    localparam int TAG_W = 32 - INDEX_W - cache_pkg::OFFSET_W
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic [INDEX_W-1:0] lookup_index,
    input  logic [TAG_W-1:0]   tag,
    input  logic               fill_valid,
    input  logic               fill_way,
    input  logic [TAG_W-1:0]   fill_tag,
    input  logic               dirty_set,
    input  logic               lru_touch,
    input  logic               access_way,
    output logic               hit,
    output logic               hit_way,
    output logic               victim_way,
    output logic               victim_dirty,
    output logic [TAG_W-1:0]   victim_tag
);

    localparam int SETS = 2 ** INDEX_W;

    logic [INDEX_W-1:0]                idx_q;
    logic [cache_pkg::NUM_WAYS-1:0]    valid_q [SETS];
    logic [cache_pkg::NUM_WAYS-1:0]    dirty_q [SETS];
    logic [SETS-1:0]                   lru_q;
    logic [TAG_W-1:0]                  way_tag [cache_pkg::NUM_WAYS];
    logic [cache_pkg::NUM_WAYS-1:0]    way_hit;

    for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++)
    begin : g_way
        sram_1rw #(
            .DATA_W  (TAG_W),
            .ADDR_W  (INDEX_W),
            .BYTE_EN (1'b0)
        ) u_tag_ram (
            .clk   (clk),
            .we    (fill_valid && fill_way == w),
            .addr  (lookup_index),
            .wdata (fill_tag),
            .rdata (way_tag[w])
        );

        assign way_hit[w] = valid_q[idx_q][w] && (way_tag[w] == tag);
    end

    // set whose tags are on the RAM outputs
    always_ff @(posedge clk)
        idx_q <= lookup_index;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lru_q <= '0;
        end
        else
        begin
            if (fill_valid)
            begin
                valid_q[idx_q][fill_way] <= 1'b1;
                dirty_q[idx_q][fill_way] <= dirty_set;
            end
            else if (dirty_set)
                dirty_q[idx_q][access_way] <= 1'b1;
            // lru bit names the way to evict next
            if (lru_touch)
                lru_q[idx_q] <= ~access_way;
        end
    end

    assign hit          = |way_hit;
    assign hit_way      = way_hit[1];
    assign victim_way   = lru_q[idx_q];
    assign victim_dirty = dirty_q[idx_q][victim_way];
    assign victim_tag   = way_tag[victim_way];

    a_one_way_hit : assert property (@(posedge clk) disable iff (!resetn) !(&way_hit));

endmodule

`default_nettype wire

// ==== rtl/cache_data_array.sv ====
`default_nettype none

module cache_data_array #(
    parameter int INDEX_W = 8
) (
    input  logic                             clk,
    input  logic [INDEX_W-1:0]               lookup_index,
    input  logic [1:0]                       offset_word,
    input  logic                             hit_way,
    input  logic                             fill_valid,
    input  logic                             fill_way,
    input  logic [1:0]                       beat,
    input  logic [cache_pkg::WORD_W-1:0]     ret_data,
    input  logic                             wb_we,
    input  logic                             wb_way,
    input  logic [1:0]                       wb_bank,
    input  logic [cache_pkg::WORD_W/8-1:0]   wb_wstrb,
    input  logic [cache_pkg::WORD_W-1:0]     wb_wdata,
    output logic [cache_pkg::WORD_W-1:0]     hit_word,
    output logic [cache_pkg::LINE_W-1:0]     victim_line
);

    localparam int WORD_W = cache_pkg::WORD_W;

    logic [WORD_W-1:0] bank_rd [cache_pkg::NUM_WAYS][cache_pkg::WORDS_PER_LINE];
    logic [WORD_W-1:0] bank_wdata;

    // refill beats win over a store commit
    assign bank_wdata = fill_valid ? ret_data : wb_wdata;

    for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++)
    begin : g_way
        for (genvar b = 0; b < cache_pkg::WORDS_PER_LINE; b++)
        begin : g_bank
            logic [WORD_W/8-1:0] bank_we;

            always_comb
            begin
                bank_we = '0;
                if (fill_valid && fill_way == w && beat == b)
                    bank_we = '1;
                else if (wb_we && wb_way == w && wb_bank == b)
                    bank_we = wb_wstrb;
            end

            sram_1rw #(
                .DATA_W  (WORD_W),
                .ADDR_W  (INDEX_W),
                .BYTE_EN (1'b1)
            ) u_bank (
                .clk   (clk),
                .we    (bank_we),
                .addr  (lookup_index),
                .wdata (bank_wdata),
                .rdata (bank_rd[w][b])
            );
        end
    end

    assign hit_word = bank_rd[hit_way][offset_word];

    // whole line of the victim way for writeback
    for (genvar b = 0; b < cache_pkg::WORDS_PER_LINE; b++)
    begin : g_victim
        assign victim_line[b*WORD_W +: WORD_W] = bank_rd[fill_way][b];
    end

endmodule

`default_nettype wire

// ==== rtl/cache_write_buffer.sv ====
`default_nettype none

module cache_write_buffer (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           wb_start,
    input  logic                           way,
    input  logic [1:0]                     wb_bank,
    input  logic [cache_pkg::WORD_W/8-1:0] wb_wstrb,
    input  logic [cache_pkg::WORD_W-1:0]   wb_wdata,
    output logic                           wb_busy,
    output logic                           wb_we,
    output logic                           wb_way,
    output logic [1:0]                     wb_bank_q,
    output logic [cache_pkg::WORD_W/8-1:0] wb_wstrb_q,
    output logic [cache_pkg::WORD_W-1:0]   wb_wdata_q
);

    cache_pkg::wb_state_e state;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            state <= cache_pkg::WB_IDLE;
        else
        begin
            case (state)
                cache_pkg::WB_IDLE:
                    if (wb_start)
                        state <= cache_pkg::WB_WRITE;
                // back to back stores keep it writing
                cache_pkg::WB_WRITE:
                    if (!wb_start)
                        state <= cache_pkg::WB_IDLE;
                default:
                    state <= cache_pkg::WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wb_start)
        begin
            wb_way     <= way;
            wb_bank_q  <= wb_bank;
            wb_wstrb_q <= wb_wstrb;
            wb_wdata_q <= wb_wdata;
        end
    end

    assign wb_we   = (state == cache_pkg::WB_WRITE);
    assign wb_busy = wb_we;

    // a new store never targets the bank still being committed
    a_no_same_bank_start : assert property (@(posedge clk) disable iff (!resetn)
        (wb_start && wb_we) |-> (wb_bank != wb_bank_q));

endmodule

`default_nettype wire

// ==== rtl/cache_ctrl.sv ====
`default_nettype none

module cache_ctrl #(
    parameter int INDEX_W = 8,
    localparam int TAG_W = 32 - INDEX_W - cache_pkg::OFFSET_W
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            valid,
    input  logic                            op,
    input  logic [INDEX_W-1:0]              index,
    input  logic [TAG_W-1:0]                tag,
    input  logic [cache_pkg::OFFSET_W-1:0]  offset,
    input  logic [cache_pkg::WORD_W/8-1:0]  wstrb,
    input  logic [cache_pkg::WORD_W-1:0]    wdata,
    input  logic                            rd_rdy,
    input  logic                            ret_valid,
    input  logic                            ret_last,
    input  logic [cache_pkg::WORD_W-1:0]    ret_data,
    input  logic                            wr_rdy,
    input  logic                            hit,
    input  logic                            hit_way,
    input  logic                            victim_way,
    input  logic                            victim_dirty,
    input  logic [TAG_W-1:0]                victim_tag,
    input  logic [cache_pkg::WORD_W-1:0]    hit_word,
    input  logic [cache_pkg::LINE_W-1:0]    victim_line,
    input  logic                            wb_busy,
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic [cache_pkg::WORD_W-1:0]    rdata,
    output logic                            rd_req,
    output logic [31:0]                     rd_addr,
    output logic                            wr_req,
    output logic [31:0]                     wr_addr,
    output logic [cache_pkg::LINE_W-1:0]    wr_data,
    output logic [INDEX_W-1:0]              lookup_index,
    output logic                            fill_valid,
    output logic                            fill_way,
    output logic [TAG_W-1:0]                fill_tag,
    output logic [1:0]                      beat,
    output logic                            dirty_set,
    output logic                            lru_touch,
    output logic                            access_way,
    output logic                            wb_start,
    output logic [1:0]                      wb_bank,
    output logic [cache_pkg::WORD_W/8-1:0]  wb_wstrb,
    output logic [cache_pkg::WORD_W-1:0]    wb_wdata
);

    cache_pkg::cache_state_e state, state_nxt;
    cache_pkg::cache_op_e    buff_op;

    logic [INDEX_W-1:0]             buff_index;
    logic [TAG_W-1:0]               buff_tag;
    logic [1:0]                     buff_word;
    logic [cache_pkg::WORD_W/8-1:0] buff_wstrb;
    logic [cache_pkg::WORD_W-1:0]   buff_wdata;
    logic [cache_pkg::WORD_W-1:0]   refill_word;
    logic                           way_q;
    logic                           resp_q;
    logic                           accept;
    logic                           lookup_hit;
    logic                           store_hit;
    logic                           last_beat;

    assign lookup_hit = (state == cache_pkg::LOOKUP) && hit;
    assign store_hit  = lookup_hit && (buff_op == cache_pkg::OP_WRITE);
    assign last_beat  = (state == cache_pkg::REFILL) && ret_valid && ret_last;

    // stall while a store is still on its way into the banks
    assign addr_ok = ((state == cache_pkg::IDLE) || lookup_hit) && !store_hit && !wb_busy;
    assign accept  = valid && addr_ok;

    always_comb
    begin
        state_nxt = state;
        case (state)
            cache_pkg::IDLE:
                if (accept)
                    state_nxt = cache_pkg::LOOKUP;
            cache_pkg::LOOKUP:
                if (hit)
                    state_nxt = accept ? cache_pkg::LOOKUP : cache_pkg::IDLE;
                else
                    state_nxt = victim_dirty ? cache_pkg::WRITEBACK : cache_pkg::REPLACE;
            cache_pkg::WRITEBACK:
                if (wr_rdy)
                    state_nxt = cache_pkg::REPLACE;
            cache_pkg::REPLACE:
                if (rd_rdy)
                    state_nxt = cache_pkg::REFILL;
            cache_pkg::REFILL:
                if (ret_valid && ret_last)
                    state_nxt = cache_pkg::IDLE;
            default:
                state_nxt = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state  <= cache_pkg::IDLE;
            beat   <= 2'd0;
            way_q  <= 1'b0;
            resp_q <= 1'b0;
        end
        else
        begin
            state  <= state_nxt;
            resp_q <= last_beat;
            if (state == cache_pkg::LOOKUP && !hit)
                way_q <= victim_way;
            if (fill_valid)
                beat <= ret_last ? 2'd0 : beat + 2'd1;
        end
    end

    // request buffer and the word picked out of the refill
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            buff_op    <= cache_pkg::cache_op_e'(op);
            buff_index <= index;
            buff_tag   <= tag;
            buff_word  <= offset[cache_pkg::OFFSET_W-1:2];
            buff_wstrb <= wstrb;
            buff_wdata <= wdata;
        end
        if (fill_valid && beat == buff_word)
            refill_word <= ret_data;
    end

    assign lookup_index = accept ? index : buff_index;

    assign data_ok = lookup_hit || resp_q;
    assign rdata   = resp_q ? refill_word : hit_word;

    assign rd_req  = (state == cache_pkg::REPLACE);
    assign rd_addr = {buff_tag, buff_index, {cache_pkg::OFFSET_W{1'b0}}};
    assign wr_req  = (state == cache_pkg::WRITEBACK) && wr_rdy;
    assign wr_addr = {victim_tag, buff_index, {cache_pkg::OFFSET_W{1'b0}}};
    assign wr_data = victim_line;

    assign fill_valid = (state == cache_pkg::REFILL) && ret_valid;
    assign fill_way   = way_q;
    assign fill_tag   = buff_tag;
    assign dirty_set  = store_hit || (fill_valid && buff_op == cache_pkg::OP_WRITE);
    assign lru_touch  = lookup_hit || fill_valid;
    assign access_way = (state == cache_pkg::LOOKUP) ? hit_way : way_q;

    // store hits, and the store that caused a refill, go to the write buffer
    assign wb_start = store_hit || (last_beat && buff_op == cache_pkg::OP_WRITE);
    assign wb_bank  = buff_word;
    assign wb_wstrb = buff_wstrb;
    assign wb_wdata = buff_wdata;

    // beats outside a refill would be lost
    a_beats_in_refill : assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> (state == cache_pkg::REFILL));

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
`default_nettype none

module cache_top #(
    parameter int INDEX_W = 8,
    localparam int TAG_W = 32 - INDEX_W - cache_pkg::OFFSET_W
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            valid,
    input  logic                            op,
    input  logic [INDEX_W-1:0]              index,
    input  logic [TAG_W-1:0]                tag,
    input  logic [cache_pkg::OFFSET_W-1:0]  offset,
    input  logic [cache_pkg::WORD_W/8-1:0]  wstrb,
    input  logic [cache_pkg::WORD_W-1:0]    wdata,
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic [cache_pkg::WORD_W-1:0]    rdata,
    output logic                            rd_req,
    output logic [31:0]                     rd_addr,
    input  logic                            rd_rdy,
    input  logic                            ret_valid,
    input  logic                            ret_last,
    input  logic [cache_pkg::WORD_W-1:0]    ret_data,
    output logic                            wr_req,
    output logic [31:0]                     wr_addr,
    output logic [cache_pkg::LINE_W-1:0]    wr_data,
    input  logic                            wr_rdy
);

    logic [INDEX_W-1:0]             lookup_index;
    logic                           hit, hit_way, victim_way, victim_dirty;
    logic [TAG_W-1:0]               victim_tag, fill_tag;
    logic [cache_pkg::WORD_W-1:0]   hit_word;
    logic [cache_pkg::LINE_W-1:0]   victim_line;
    logic                           fill_valid, fill_way, dirty_set, lru_touch, access_way;
    logic [1:0]                     beat;
    logic                           wb_start, wb_busy, wb_we, wb_way;
    logic [1:0]                     wb_bank, wb_bank_q;
    logic [cache_pkg::WORD_W/8-1:0] wb_wstrb, wb_wstrb_q;
    logic [cache_pkg::WORD_W-1:0]   wb_wdata, wb_wdata_q;

    cache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (.*);

    // buffered tag doubles as the compare tag
    cache_tag_array #(.INDEX_W(INDEX_W)) u_tag_array (
        .clk, .resetn, .lookup_index,
        .tag          (fill_tag),
        .fill_valid, .fill_way, .fill_tag, .dirty_set, .lru_touch, .access_way,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    // buffered word offset also selects the hit word
    cache_data_array #(.INDEX_W(INDEX_W)) u_data_array (
        .clk, .lookup_index,
        .offset_word  (wb_bank),
        .hit_way, .fill_valid, .fill_way, .beat, .ret_data, .wb_we, .wb_way,
        .wb_bank      (wb_bank_q),
        .wb_wstrb     (wb_wstrb_q),
        .wb_wdata     (wb_wdata_q),
        .hit_word, .victim_line
    );

    cache_write_buffer u_write_buffer (
        .clk, .resetn, .wb_start,
        .way          (access_way),
        .wb_bank, .wb_wstrb, .wb_wdata,
        .wb_busy, .wb_we, .wb_way, .wb_bank_q, .wb_wstrb_q, .wb_wdata_q
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic resetn
);

    initial
    begin
        clk    = 1'b0;
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        // release away from the active edge
        @(negedge clk);
        resetn = 1'b1;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`default_nettype none

module mem_model (
    input  logic         clk,
    input  logic         resetn,
    input  logic         rd_req,
    input  logic [31:0]  rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output logic [31:0]  ret_data,
    input  logic         wr_req,
    input  logic [31:0]  wr_addr,
    input  logic [127:0] wr_data,
    output logic         wr_rdy
);

    // words written back by the cache override the pattern
    logic [31:0] store [logic [31:0]];
    logic [31:0] base;
    logic [1:0]  rd_wait;
    logic [1:0]  wr_wait;
    logic [1:0]  beat;
    logic        bursting;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (store.exists(a))
            return store[a];
        return a ^ 32'h5a5a0000;
    endfunction

    initial
    begin
        void'($urandom(32'hcde55ad6));
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        base      = '0;
        rd_wait   = '0;
        wr_wait   = '0;
        beat      = '0;
        bursting  = 1'b0;
    end

    always @(posedge clk)
    begin
        if (!resetn)
        begin
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            wr_rdy    <= 1'b0;
            bursting  <= 1'b0;
            rd_wait   <= '0;
            wr_wait   <= '0;
            beat      <= '0;
        end
        else
        begin
            // rd_rdy rises after 0 to 3 idle cycles
            rd_rdy <= 1'b0;
            if (rd_req && rd_rdy)
            begin
                base     <= rd_addr;
                bursting <= 1'b1;
                beat     <= '0;
                rd_wait  <= 2'($urandom % 4);
            end
            else if (rd_req)
            begin
                if (rd_wait == 0)
                    rd_rdy <= 1'b1;
                else
                    rd_wait <= rd_wait - 2'd1;
            end
            // four beats with random gaps
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (bursting && ($urandom % 4) != 0)
            begin
                ret_valid <= 1'b1;
                ret_data  <= word_at(base + 32'(beat) * 4);
                ret_last  <= (beat == 2'd3);
                beat      <= beat + 2'd1;
                if (beat == 2'd3)
                    bursting <= 1'b0;
            end
            // wr_rdy pulses every 1 to 4 cycles
            if (wr_wait == 0)
            begin
                wr_rdy  <= 1'b1;
                wr_wait <= 2'($urandom % 4);
            end
            else
            begin
                wr_rdy  <= 1'b0;
                wr_wait <= wr_wait - 2'd1;
            end
            if (wr_req)
            begin
                for (int i = 0; i < 4; i++)
                    store[wr_addr + 32'(i) * 4] = wr_data[i*32 +: 32];
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_cache.sv ====
`default_nettype none

module tb_cache;

    localparam int COLS      = 7;
    localparam int MAX_TESTS = 32;

    logic         clk, resetn;
    logic         valid, op;
    logic [7:0]   index;
    logic [19:0]  tag;
    logic [3:0]   offset, wstrb;
    logic [31:0]  wdata, rdata, rd_addr, wr_addr, ret_data;
    logic         addr_ok, data_ok, rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    logic [127:0] wr_data;

    // seven words per access in file column order
    logic [31:0]  vec [COLS*MAX_TESTS];
    int           num_tests;
    int           wr_count;
    int           errors;
    int           passed;

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(5)) u_clock_gen (.clk, .resetn);

    cache_top #(.INDEX_W(8)) u_cache_top (.*);

    mem_model u_mem_model (.*);

    always @(posedge clk)
        if (resetn && wr_req)
            wr_count++;

    task automatic run_access(input int t);
        logic [31:0] addr;
        int          lat;
        int          wr_before;
        int          bad;
        addr      = vec[t*COLS+1];
        bad       = 0;
        wr_before = wr_count;
        op        = vec[t*COLS][0];
        tag       = addr[31:12];
        index     = addr[11:4];
        offset    = addr[3:0];
        wstrb     = vec[t*COLS+2][3:0];
        wdata     = vec[t*COLS+3];
        valid     = 1'b1;
        #1;
        while (!addr_ok)
        begin
            @(negedge clk);
            #1;
        end
        // accepted at the coming edge
        @(negedge clk);
        valid = 1'b0;
        lat   = 1;
        while (!data_ok)
        begin
            @(negedge clk);
            lat++;
        end
        if (!op && rdata !== vec[t*COLS+4])
        begin
            $display("error at %0t: test %0d read %h, expected %h",
                     $time, t, rdata, vec[t*COLS+4]);
            bad++;
        end
        if (wr_count - wr_before != int'(vec[t*COLS+5]))
        begin
            $display("error at %0t: test %0d saw %0d writebacks, expected %0d",
                     $time, t, wr_count - wr_before, vec[t*COLS+5]);
            bad++;
        end
        if (vec[t*COLS+6] != 0 && lat != 1)
        begin
            $display("error at %0t: test %0d hit took %0d cycles", $time, t, lat);
            bad++;
        end
        if (bad == 0)
            passed++;
        errors += bad;
        $display("test %0d %s %h: %s", t, op ? "write" : "read", addr, bad ? "bad" : "ok");
    endtask

    initial
    begin
        valid     = 1'b0;
        op        = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        wr_count  = 0;
        errors    = 0;
        passed    = 0;
        num_tests = 0;
        for (int i = 0; i < COLS * MAX_TESTS; i++)
            vec[i] = '1;
        $readmemh("tb/cache_testdata.txt", vec);
        while (num_tests < MAX_TESTS && vec[num_tests*COLS] != 32'hffffffff)
            num_tests++;
        wait (resetn);
        @(negedge clk);
        for (int t = 0; t < num_tests; t++)
            run_access(t);
        $display("tests %0d, passed %0d, errors %0d", num_tests, passed, errors);
        if (errors == 0 && num_tests > 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog allows 300 cycles per access
    initial
    begin
        @(posedge resetn);
        repeat (300 * num_tests + 20) @(posedge clk);
        $display("timeout: the accesses did not complete in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cache_testdata.txt ====
// op addr mask wdata expected_rdata writebacks hit_latency_check
// set 0x10 takes tags 1 to 4, set 0x20 takes tag 0x50
0 00001104 0 00000000 5a5a1104 0 0
0 00001108 0 00000000 5a5a1108 0 1
0 0000110c 0 00000000 5a5a110c 0 1
1 00001104 3 aabbccdd 00000000 0 1
0 00001104 0 00000000 5a5accdd 0 1
1 00002108 c 11223344 00000000 0 0
0 00002108 0 00000000 11222108 0 1
// dirty victims go back to memory
0 00003100 0 00000000 5a5a3100 1 0
0 00001104 0 00000000 5a5accdd 1 0
0 00003104 0 00000000 5a5a3104 0 1
// clean victims
0 00004100 0 00000000 5a5a4100 0 0
0 00002108 0 00000000 11222108 0 0
1 00050200 f deadbeef 00000000 0 0
0 00050200 0 00000000 deadbeef 0 1
0 0005020c 0 00000000 5a5f020c 0 1
1 00050204 1 000000aa 00000000 0 1
0 00050204 0 00000000 5a5f02aa 0 1

// ==== project.f ====
rtl/cache_pkg.sv
rtl/sram_1rw.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/cache_write_buffer.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
tb/tb_clock_gen.sv
tb/mem_model.sv
tb/tb_cache.sv
